// File: Bender.yml
package:
  name: decode_stage

sources:
  - include_dirs:
      - hw
    files:
      - hw/isa_pkg.sv
      - hw/ctrl_pkg.sv
      - hw/rtype_decoder.sv
      - hw/regimm_decoder.sv
      - hw/special2_decoder.sv
      - hw/main_decoder.sv
      - hw/decode_stage.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tests/decode_stage_tb.sv

// File: hw/ctrl_pkg.sv
`include "decoder_config.svh"

package ctrl_pkg;

    typedef enum logic [1:0] {OPD_NONE, OPD_RS, OPD_RT, OPD_RS_RT} opd_use_t;
    typedef enum logic [2:0] {PC_SEQ, PC_BRANCH, PC_JUMP, PC_JUMP_REG, PC_EXCEPTION} pc_src_t;
    typedef enum logic [2:0] {
        EXC_NONE, EXC_OVERFLOW, EXC_RESERVED, EXC_SYSCALL, EXC_BREAK
    } exc_chk_t;
    typedef enum logic [1:0] {REG_SRC_ALU, REG_SRC_FLAG, REG_SRC_MEM, REG_SRC_PCADD8} reg_src_t;
    typedef enum logic [1:0] {DEST_RD, DEST_RT, DEST_LINK} dest_reg_t;
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR, ALU_SLL,
        ALU_SRL, ALU_SRA, ALU_MUL, ALU_CLZ, ALU_CLO, ALU_NCARE = 4'hf
    } alu_op_t;
    typedef enum logic [2:0] {
        FLAG_EQ, FLAG_NE, FLAG_LE, FLAG_GT, FLAG_LT, FLAG_GE, FLAG_LTU
    } flag_t;
    typedef enum logic [2:0] {IMM_NONE, IMM_SIGN, IMM_ZERO, IMM_UPPER, IMM_SHAMT} imm_sel_t;
    typedef enum logic [2:0] {
        MEM_READ_NONE, MEM_READ_BYTE, MEM_READ_HALF,
        MEM_READ_WORD, MEM_READ_UBYTE, MEM_READ_UHALF
    } mem_read_t;
    typedef enum logic [1:0] {
        MEM_WRITE_NONE, MEM_WRITE_BYTE, MEM_WRITE_HALF, MEM_WRITE_WORD
    } mem_write_t;

    typedef struct packed {
        opd_use_t   opd_use;
        pc_src_t    pc_src;
        exc_chk_t   exc_chk;
        logic       write_reg;
        reg_src_t   reg_src;
        dest_reg_t  dest_reg;
        alu_op_t    alu_op;
        flag_t      flag;
        imm_sel_t   imm_sel;
        logic       write_mem;
        mem_read_t  read_mode;
        mem_write_t write_mode;
    } control_t;

    function automatic control_t get_default_control();
        return '{OPD_NONE, PC_SEQ, EXC_NONE, 1'b0, REG_SRC_ALU, DEST_RD, ALU_NCARE,
                 FLAG_EQ, IMM_NONE, 1'b0, MEM_READ_NONE, MEM_WRITE_NONE};
    endfunction

    function automatic control_t get_reserved_control();
        control_t c;
        c = get_default_control();
        c.pc_src = PC_EXCEPTION;
        c.exc_chk = EXC_RESERVED;
        return c;
    endfunction

    function automatic void branch_with(inout control_t c, input flag_t f);
        c.opd_use = OPD_RS_RT; // BLEZ and BGTZ carry $0 in rt.
        c.pc_src = PC_BRANCH;
        c.imm_sel = IMM_SIGN;
        c.flag = f;
    endfunction

    function automatic void write_alu_to_rt(inout control_t c, input alu_op_t op);
        c.write_reg = 1'b1;
        c.reg_src = REG_SRC_ALU;
        c.dest_reg = DEST_RT;
        c.alu_op = op;
    endfunction

    function automatic void write_flag_to_rt(inout control_t c, input flag_t f);
        c.write_reg = 1'b1;
        c.reg_src = REG_SRC_FLAG;
        c.dest_reg = DEST_RT;
        c.flag = f;
    endfunction

    // resolves the destination selector to the register index written back.
    function automatic isa_pkg::reg_idx_t dest_index(control_t c, isa_pkg::reg_idx_t rt,
                                                     isa_pkg::reg_idx_t rd);
        case (c.dest_reg)
            DEST_RT: return rt;
            DEST_LINK: return isa_pkg::reg_idx_t'(`DEC_LINK_REG);
            default: return rd;
        endcase
    endfunction

endpackage

// File: hw/decode_stage.sv
module decode_stage (
    input  logic               clk,
    input  logic               reset,
    input  logic               in_valid,
    input  isa_pkg::instr_t    instruction,
    input  logic               stall,
    input  logic               flush,
    output logic               out_valid,
    output ctrl_pkg::control_t ctl,
    output isa_pkg::reg_idx_t  rs,
    output isa_pkg::reg_idx_t  rt,
    output isa_pkg::reg_idx_t  rd,
    output isa_pkg::shamt_t    shamt,
    output isa_pkg::imm16_t    imm
);
    isa_pkg::instr_t    instr_q;
    logic               instr_valid;
    ctrl_pkg::control_t dec_ctl;

    main_decoder u_main_decoder (
        .instruction(instr_q),
        .ctl(dec_ctl)
    );

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            instr_valid <= 1'b0;
            out_valid <= 1'b0;
            ctl <= ctrl_pkg::get_default_control();
        end else if (!stall) begin
            instr_valid <= in_valid;
            out_valid <= instr_valid;
            // a bubble carries the default bundle so nothing downstream writes.
            ctl <= instr_valid ? dec_ctl : ctrl_pkg::get_default_control();
        end
    end

    always_ff @(posedge clk) begin
        if (!stall && in_valid)
            instr_q <= instruction;
        if (!stall && instr_valid) begin
            rs <= instr_q[25:21];
            rt <= instr_q[20:16];
            rd <= instr_q[15:11];
            shamt <= instr_q[10:6];
            imm <= instr_q[15:0];
        end
    end

    // the word that was in flight at the flush must not surface one cycle later.
    assert property (@(posedge clk) disable iff (reset) flush |=> !out_valid ##1 !out_valid)
        else $error("decode_stage: a flushed word reached out_valid.");

endmodule

// File: hw/decoder_config.svh
`ifndef DECODER_CONFIG_SVH
`define DECODER_CONFIG_SVH

// instruction word width in bits.
`define DEC_INSTR_WIDTH 32

// width of a general purpose register index.
`define DEC_REG_IDX_WIDTH 5

// register written by JAL and the linking branches.
`define DEC_LINK_REG 31

`endif

// File: hw/isa_pkg.sv
`include "decoder_config.svh"

package isa_pkg;

    typedef logic [`DEC_INSTR_WIDTH-1:0] instr_t;
    typedef logic [`DEC_REG_IDX_WIDTH-1:0] reg_idx_t;
    typedef logic [15:0] imm16_t;
    typedef logic [`DEC_REG_IDX_WIDTH-1:0] shamt_t;

    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,   OP_REGIMM = 6'h01,
        OP_J     = 6'h02,   OP_JAL    = 6'h03,
        OP_BEQ   = 6'h04,   OP_BNE    = 6'h05,
        OP_BLEZ  = 6'h06,   OP_BGTZ   = 6'h07,
        OP_ADDI  = 6'h08,   OP_ADDIU  = 6'h09,
        OP_SLTI  = 6'h0a,   OP_SLTIU  = 6'h0b,
        OP_ANDI  = 6'h0c,   OP_ORI    = 6'h0d,
        OP_XORI  = 6'h0e,   OP_LUI    = 6'h0f,
        OP_BEQL  = 6'h14,   OP_BNEL   = 6'h15,
        OP_BLEZL = 6'h16,   OP_BGTZL  = 6'h17,
        OP_SPECIAL2 = 6'h1c,
        OP_LB    = 6'h20,   OP_LH     = 6'h21,
        OP_LW    = 6'h23,   OP_LBU    = 6'h24,
        OP_LHU   = 6'h25,   OP_SB     = 6'h28,
        OP_SH    = 6'h29,   OP_SW     = 6'h2b
    } opcode_t;

    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,    FN_SRL     = 6'h02,
        FN_SRA  = 6'h03,    FN_SLLV    = 6'h04,
        FN_SRLV = 6'h06,    FN_SRAV    = 6'h07,
        FN_JR   = 6'h08,    FN_JALR    = 6'h09,
        FN_SYSCALL = 6'h0c, FN_BREAK   = 6'h0d,
        FN_ADD  = 6'h20,    FN_ADDU    = 6'h21,
        FN_SUB  = 6'h22,    FN_SUBU    = 6'h23,
        FN_AND  = 6'h24,    FN_OR      = 6'h25,
        FN_XOR  = 6'h26,    FN_NOR     = 6'h27,
        FN_SLT  = 6'h2a,    FN_SLTU    = 6'h2b
    } funct_t;

    // SPECIAL2 reuses R-type funct values, so its codes cannot be enum members.
    localparam funct_t FN_MUL = funct_t'(6'h02);
    localparam funct_t FN_CLZ = funct_t'(6'h20);
    localparam funct_t FN_CLO = funct_t'(6'h21);

    typedef enum logic [4:0] {
        RI_BLTZ   = 5'h00,
        RI_BGEZ   = 5'h01,
        RI_BLTZAL = 5'h10,
        RI_BGEZAL = 5'h11
    } regimm_t;

endpackage

// File: hw/main_decoder.sv
module main_decoder (
    input  isa_pkg::instr_t    instruction,
    output ctrl_pkg::control_t ctl
);
    isa_pkg::opcode_t   opcode;
    ctrl_pkg::control_t rtype_ctl;
    ctrl_pkg::control_t regimm_ctl;
    ctrl_pkg::control_t special2_ctl;

    assign opcode = isa_pkg::opcode_t'(instruction[31:26]);

    rtype_decoder u_rtype (
        .instruction(instruction),
        .ctl(rtype_ctl)
    );

    regimm_decoder u_regimm (
        .instruction(instruction),
        .ctl(regimm_ctl)
    );

    special2_decoder u_special2 (
        .instruction(instruction),
        .ctl(special2_ctl)
    );

    always_comb begin
        ctl = ctrl_pkg::get_default_control();
        case (opcode)
            isa_pkg::OP_RTYPE:    ctl = rtype_ctl;
            isa_pkg::OP_REGIMM:   ctl = regimm_ctl;
            isa_pkg::OP_SPECIAL2: ctl = special2_ctl;
            isa_pkg::OP_J, isa_pkg::OP_JAL: begin
                ctl.pc_src = ctrl_pkg::PC_JUMP;
                if (opcode == isa_pkg::OP_JAL) begin
                    ctl.write_reg = 1'b1;
                    ctl.reg_src = ctrl_pkg::REG_SRC_PCADD8;
                    ctl.dest_reg = ctrl_pkg::DEST_LINK;
                end
            end
            // the likely forms decode as plain branches, annulment is handled later.
            isa_pkg::OP_BEQ, isa_pkg::OP_BEQL:
                ctrl_pkg::branch_with(ctl, ctrl_pkg::FLAG_EQ);
            isa_pkg::OP_BNE, isa_pkg::OP_BNEL:
                ctrl_pkg::branch_with(ctl, ctrl_pkg::FLAG_NE);
            isa_pkg::OP_BLEZ, isa_pkg::OP_BLEZL:
                ctrl_pkg::branch_with(ctl, ctrl_pkg::FLAG_LE);
            isa_pkg::OP_BGTZ, isa_pkg::OP_BGTZL:
                ctrl_pkg::branch_with(ctl, ctrl_pkg::FLAG_GT);
            isa_pkg::OP_ADDI, isa_pkg::OP_ADDIU: begin
                ctl.opd_use = ctrl_pkg::OPD_RS;
                ctl.imm_sel = ctrl_pkg::IMM_SIGN;
                ctrl_pkg::write_alu_to_rt(ctl, ctrl_pkg::ALU_ADD);
                if (opcode == isa_pkg::OP_ADDI)
                    ctl.exc_chk = ctrl_pkg::EXC_OVERFLOW;
            end
            isa_pkg::OP_SLTI, isa_pkg::OP_SLTIU: begin
                ctl.opd_use = ctrl_pkg::OPD_RS;
                ctl.imm_sel = ctrl_pkg::IMM_SIGN; // SLTIU also sign extends.
                if (opcode == isa_pkg::OP_SLTIU)
                    ctrl_pkg::write_flag_to_rt(ctl, ctrl_pkg::FLAG_LTU);
                else
                    ctrl_pkg::write_flag_to_rt(ctl, ctrl_pkg::FLAG_LT);
            end
            isa_pkg::OP_ANDI, isa_pkg::OP_ORI, isa_pkg::OP_XORI: begin
                ctl.opd_use = ctrl_pkg::OPD_RS;
                ctl.imm_sel = ctrl_pkg::IMM_ZERO;
                if (opcode == isa_pkg::OP_ANDI)
                    ctrl_pkg::write_alu_to_rt(ctl, ctrl_pkg::ALU_AND);
                else if (opcode == isa_pkg::OP_ORI)
                    ctrl_pkg::write_alu_to_rt(ctl, ctrl_pkg::ALU_OR);
                else
                    ctrl_pkg::write_alu_to_rt(ctl, ctrl_pkg::ALU_XOR);
            end
            isa_pkg::OP_LB, isa_pkg::OP_LH, isa_pkg::OP_LW,
            isa_pkg::OP_LBU, isa_pkg::OP_LHU: begin
                ctl.opd_use = ctrl_pkg::OPD_RS;
                ctl.imm_sel = ctrl_pkg::IMM_SIGN;
                ctrl_pkg::write_alu_to_rt(ctl, ctrl_pkg::ALU_ADD); // the ALU forms the address.
                ctl.reg_src = ctrl_pkg::REG_SRC_MEM;
                case (opcode)
                    isa_pkg::OP_LB:  ctl.read_mode = ctrl_pkg::MEM_READ_BYTE;
                    isa_pkg::OP_LH:  ctl.read_mode = ctrl_pkg::MEM_READ_HALF;
                    isa_pkg::OP_LBU: ctl.read_mode = ctrl_pkg::MEM_READ_UBYTE;
                    isa_pkg::OP_LHU: ctl.read_mode = ctrl_pkg::MEM_READ_UHALF;
                    default:         ctl.read_mode = ctrl_pkg::MEM_READ_WORD;
                endcase
            end
            isa_pkg::OP_SB, isa_pkg::OP_SH, isa_pkg::OP_SW: begin
                ctl.opd_use = ctrl_pkg::OPD_RS_RT;
                ctl.imm_sel = ctrl_pkg::IMM_SIGN;
                ctl.alu_op = ctrl_pkg::ALU_ADD;
                ctl.write_mem = 1'b1;
                case (opcode)
                    isa_pkg::OP_SB: ctl.write_mode = ctrl_pkg::MEM_WRITE_BYTE;
                    isa_pkg::OP_SH: ctl.write_mode = ctrl_pkg::MEM_WRITE_HALF;
                    default:        ctl.write_mode = ctrl_pkg::MEM_WRITE_WORD;
                endcase
            end
            isa_pkg::OP_LUI: begin
                ctl.imm_sel = ctrl_pkg::IMM_UPPER; // the shifted immediate is added to zero.
                ctrl_pkg::write_alu_to_rt(ctl, ctrl_pkg::ALU_ADD);
            end
            default: ctl = ctrl_pkg::get_reserved_control();
        endcase
    end

    assert property (@(instruction)
        (opcode inside {isa_pkg::OP_SB, isa_pkg::OP_SH, isa_pkg::OP_SW}) |-> !ctl.write_reg)
        else $error("main_decoder: store decoded with a register write.");

endmodule

// File: hw/regimm_decoder.sv
module regimm_decoder (
    input  isa_pkg::instr_t    instruction,
    output ctrl_pkg::control_t ctl
);
    isa_pkg::regimm_t rt_code;

    assign rt_code = isa_pkg::regimm_t'(instruction[20:16]);

    always_comb begin
        ctl = ctrl_pkg::get_default_control();
        case (rt_code)
            isa_pkg::RI_BLTZ, isa_pkg::RI_BLTZAL: begin
                ctrl_pkg::branch_with(ctl, ctrl_pkg::FLAG_LT);
                ctl.opd_use = ctrl_pkg::OPD_RS; // rt holds the sub-opcode here.
            end
            isa_pkg::RI_BGEZ, isa_pkg::RI_BGEZAL: begin
                ctrl_pkg::branch_with(ctl, ctrl_pkg::FLAG_GE);
                ctl.opd_use = ctrl_pkg::OPD_RS;
            end
            default: ctl = ctrl_pkg::get_reserved_control();
        endcase
        if (rt_code == isa_pkg::RI_BLTZAL || rt_code == isa_pkg::RI_BGEZAL) begin
            ctl.write_reg = 1'b1; // the AL forms link whether or not the branch is taken.
            ctl.reg_src = ctrl_pkg::REG_SRC_PCADD8;
            ctl.dest_reg = ctrl_pkg::DEST_LINK;
        end
    end

endmodule

// File: hw/rtype_decoder.sv
module rtype_decoder (
    input  isa_pkg::instr_t    instruction,
    output ctrl_pkg::control_t ctl
);
    isa_pkg::funct_t funct;

    assign funct = isa_pkg::funct_t'(instruction[5:0]);

    always_comb begin
        ctl = ctrl_pkg::get_default_control();
        ctl.opd_use = ctrl_pkg::OPD_RS_RT; // most R-type ops write rs op rt to rd.
        ctl.write_reg = 1'b1;
        ctl.dest_reg = ctrl_pkg::DEST_RD;
        case (funct)
            isa_pkg::FN_ADD: begin
                ctl.alu_op = ctrl_pkg::ALU_ADD;
                ctl.exc_chk = ctrl_pkg::EXC_OVERFLOW;
            end
            isa_pkg::FN_SUB: begin
                ctl.alu_op = ctrl_pkg::ALU_SUB;
                ctl.exc_chk = ctrl_pkg::EXC_OVERFLOW;
            end
            isa_pkg::FN_ADDU: ctl.alu_op = ctrl_pkg::ALU_ADD;
            isa_pkg::FN_SUBU: ctl.alu_op = ctrl_pkg::ALU_SUB;
            isa_pkg::FN_AND:  ctl.alu_op = ctrl_pkg::ALU_AND;
            isa_pkg::FN_OR:   ctl.alu_op = ctrl_pkg::ALU_OR;
            isa_pkg::FN_XOR:  ctl.alu_op = ctrl_pkg::ALU_XOR;
            isa_pkg::FN_NOR:  ctl.alu_op = ctrl_pkg::ALU_NOR;
            isa_pkg::FN_SLT: begin
                ctl.reg_src = ctrl_pkg::REG_SRC_FLAG;
                ctl.flag = ctrl_pkg::FLAG_LT;
            end
            isa_pkg::FN_SLTU: begin
                ctl.reg_src = ctrl_pkg::REG_SRC_FLAG;
                ctl.flag = ctrl_pkg::FLAG_LTU;
            end
            isa_pkg::FN_SLL, isa_pkg::FN_SRL, isa_pkg::FN_SRA: begin
                ctl.opd_use = ctrl_pkg::OPD_RT; // the shift amount comes from the word.
                ctl.imm_sel = ctrl_pkg::IMM_SHAMT;
                if (funct == isa_pkg::FN_SLL)
                    ctl.alu_op = ctrl_pkg::ALU_SLL;
                else if (funct == isa_pkg::FN_SRL)
                    ctl.alu_op = ctrl_pkg::ALU_SRL;
                else
                    ctl.alu_op = ctrl_pkg::ALU_SRA;
            end
            isa_pkg::FN_SLLV: ctl.alu_op = ctrl_pkg::ALU_SLL;
            isa_pkg::FN_SRLV: ctl.alu_op = ctrl_pkg::ALU_SRL;
            isa_pkg::FN_SRAV: ctl.alu_op = ctrl_pkg::ALU_SRA;
            isa_pkg::FN_JR, isa_pkg::FN_JALR: begin
                ctl.opd_use = ctrl_pkg::OPD_RS;
                ctl.pc_src = ctrl_pkg::PC_JUMP_REG;
                ctl.reg_src = ctrl_pkg::REG_SRC_PCADD8;
                ctl.write_reg = (funct == isa_pkg::FN_JALR); // only JALR links.
            end
            isa_pkg::FN_SYSCALL, isa_pkg::FN_BREAK: begin
                ctl = ctrl_pkg::get_default_control();
                ctl.pc_src = ctrl_pkg::PC_EXCEPTION;
                if (funct == isa_pkg::FN_SYSCALL)
                    ctl.exc_chk = ctrl_pkg::EXC_SYSCALL;
                else
                    ctl.exc_chk = ctrl_pkg::EXC_BREAK;
            end
            default: ctl = ctrl_pkg::get_reserved_control();
        endcase
    end

    assert property (@(instruction) !(ctl.write_reg && ctl.write_mem))
        else $error("rtype_decoder: register and memory write both set.");

endmodule

// File: hw/special2_decoder.sv
module special2_decoder (
    input  isa_pkg::instr_t    instruction,
    output ctrl_pkg::control_t ctl
);
    isa_pkg::funct_t funct;

    assign funct = isa_pkg::funct_t'(instruction[5:0]);

    always_comb begin
        ctl = ctrl_pkg::get_default_control();
        ctl.write_reg = 1'b1;
        ctl.dest_reg = ctrl_pkg::DEST_RD;
        case (funct)
            isa_pkg::FN_MUL: begin
                ctl.opd_use = ctrl_pkg::OPD_RS_RT;
                ctl.alu_op = ctrl_pkg::ALU_MUL; // low word of the product only.
            end
            isa_pkg::FN_CLZ: begin
                ctl.opd_use = ctrl_pkg::OPD_RS;
                ctl.alu_op = ctrl_pkg::ALU_CLZ;
            end
            isa_pkg::FN_CLO: begin
                ctl.opd_use = ctrl_pkg::OPD_RS;
                ctl.alu_op = ctrl_pkg::ALU_CLO;
            end
            default: ctl = ctrl_pkg::get_reserved_control();
        endcase
    end

endmodule

// File: src.f
+incdir+hw
hw/isa_pkg.sv
hw/ctrl_pkg.sv
hw/rtype_decoder.sv
hw/regimm_decoder.sv
hw/special2_decoder.sv
hw/main_decoder.sv
hw/decode_stage.sv
tests/decode_stage_tb.sv

// File: tests/decode_stage_tb.sv
module decode_stage_tb;
    timeunit 1ns;
    timeprecision 100ps;

    logic               clk;
    logic               reset;
    logic               in_valid;
    isa_pkg::instr_t    instruction;
    logic               stall;
    logic               flush;
    logic               out_valid;
    ctrl_pkg::control_t ctl;
    isa_pkg::reg_idx_t  rs;
    isa_pkg::reg_idx_t  rt;
    isa_pkg::reg_idx_t  rd;
    isa_pkg::shamt_t    shamt;
    isa_pkg::imm16_t    imm;

    logic [31:0] rng;
    int          checks;
    int          errors;
    int          test_errors;

    decode_stage dut (
        .clk(clk),
        .reset(reset),
        .in_valid(in_valid),
        .instruction(instruction),
        .stall(stall),
        .flush(flush),
        .out_valid(out_valid),
        .ctl(ctl),
        .rs(rs),
        .rt(rt),
        .rd(rd),
        .shamt(shamt),
        .imm(imm)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic ctrl_pkg::control_t idle_control();
        ctrl_pkg::control_t c;
        c.opd_use = ctrl_pkg::OPD_NONE;
        c.pc_src = ctrl_pkg::PC_SEQ;
        c.exc_chk = ctrl_pkg::EXC_NONE;
        c.write_reg = 1'b0;
        c.reg_src = ctrl_pkg::REG_SRC_ALU;
        c.dest_reg = ctrl_pkg::DEST_RD;
        c.alu_op = ctrl_pkg::ALU_NCARE;
        c.flag = ctrl_pkg::FLAG_EQ;
        c.imm_sel = ctrl_pkg::IMM_NONE;
        c.write_mem = 1'b0;
        c.read_mode = ctrl_pkg::MEM_READ_NONE;
        c.write_mode = ctrl_pkg::MEM_WRITE_NONE;
        return c;
    endfunction

    function automatic ctrl_pkg::control_t trap_control(input ctrl_pkg::exc_chk_t cause);
        ctrl_pkg::control_t c;
        c = idle_control();
        c.pc_src = ctrl_pkg::PC_EXCEPTION;
        c.exc_chk = cause;
        return c;
    endfunction

    function automatic ctrl_pkg::alu_op_t shift_op(input logic [1:0] kind);
        case (kind)
            2'b00: return ctrl_pkg::ALU_SLL;
            2'b10: return ctrl_pkg::ALU_SRL;
            default: return ctrl_pkg::ALU_SRA;
        endcase
    endfunction

    // builds the expected bundle straight from the MIPS encoding.
    function automatic ctrl_pkg::control_t expected_control(input isa_pkg::instr_t w);
        ctrl_pkg::control_t c;
        logic [5:0] op;
        logic [5:0] fn;
        logic [4:0] code;
        logic       to_rt;
        op = w[31:26];
        fn = w[5:0];
        code = w[20:16];
        to_rt = 1'b0;
        c = idle_control();
        case (op)
            6'h00: begin
                c.opd_use = ctrl_pkg::OPD_RS_RT;
                c.write_reg = 1'b1;
                case (fn)
                    6'h20, 6'h21: c.alu_op = ctrl_pkg::ALU_ADD;
                    6'h22, 6'h23: c.alu_op = ctrl_pkg::ALU_SUB;
                    6'h24: c.alu_op = ctrl_pkg::ALU_AND;
                    6'h25: c.alu_op = ctrl_pkg::ALU_OR;
                    6'h26: c.alu_op = ctrl_pkg::ALU_XOR;
                    6'h27: c.alu_op = ctrl_pkg::ALU_NOR;
                    6'h2a, 6'h2b: begin
                        c.reg_src = ctrl_pkg::REG_SRC_FLAG;
                        c.flag = fn[0] ? ctrl_pkg::FLAG_LTU : ctrl_pkg::FLAG_LT;
                    end
                    6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07: begin
                        c.alu_op = shift_op(fn[1:0]);
                        if (!fn[2]) begin
                            c.opd_use = ctrl_pkg::OPD_RT; // constant shifts read rt only.
                            c.imm_sel = ctrl_pkg::IMM_SHAMT;
                        end
                    end
                    6'h08, 6'h09: begin
                        c.opd_use = ctrl_pkg::OPD_RS;
                        c.pc_src = ctrl_pkg::PC_JUMP_REG;
                        c.reg_src = ctrl_pkg::REG_SRC_PCADD8;
                        c.write_reg = fn[0];
                    end
                    6'h0c: c = trap_control(ctrl_pkg::EXC_SYSCALL);
                    6'h0d: c = trap_control(ctrl_pkg::EXC_BREAK);
                    default: c = trap_control(ctrl_pkg::EXC_RESERVED);
                endcase
                if (fn == 6'h20 || fn == 6'h22)
                    c.exc_chk = ctrl_pkg::EXC_OVERFLOW;
            end
            6'h01: begin
                if (code inside {5'h00, 5'h01, 5'h10, 5'h11}) begin
                    c.opd_use = ctrl_pkg::OPD_RS;
                    c.pc_src = ctrl_pkg::PC_BRANCH;
                    c.imm_sel = ctrl_pkg::IMM_SIGN;
                    c.flag = code[0] ? ctrl_pkg::FLAG_GE : ctrl_pkg::FLAG_LT;
                    if (code[4]) begin
                        c.write_reg = 1'b1;
                        c.reg_src = ctrl_pkg::REG_SRC_PCADD8;
                        c.dest_reg = ctrl_pkg::DEST_LINK;
                    end
                end else begin
                    c = trap_control(ctrl_pkg::EXC_RESERVED);
                end
            end
            6'h1c: begin
                c.write_reg = 1'b1;
                c.opd_use = ctrl_pkg::OPD_RS;
                case (fn)
                    6'h02: begin
                        c.opd_use = ctrl_pkg::OPD_RS_RT;
                        c.alu_op = ctrl_pkg::ALU_MUL;
                    end
                    6'h20: c.alu_op = ctrl_pkg::ALU_CLZ;
                    6'h21: c.alu_op = ctrl_pkg::ALU_CLO;
                    default: c = trap_control(ctrl_pkg::EXC_RESERVED);
                endcase
            end
            6'h02, 6'h03: begin
                c.pc_src = ctrl_pkg::PC_JUMP;
                if (op[0]) begin
                    c.write_reg = 1'b1;
                    c.reg_src = ctrl_pkg::REG_SRC_PCADD8;
                    c.dest_reg = ctrl_pkg::DEST_LINK;
                end
            end
            6'h04, 6'h05, 6'h06, 6'h07, 6'h14, 6'h15, 6'h16, 6'h17: begin
                c.opd_use = ctrl_pkg::OPD_RS_RT;
                c.pc_src = ctrl_pkg::PC_BRANCH;
                c.imm_sel = ctrl_pkg::IMM_SIGN;
                case (op[1:0])
                    2'b00: c.flag = ctrl_pkg::FLAG_EQ;
                    2'b01: c.flag = ctrl_pkg::FLAG_NE;
                    2'b10: c.flag = ctrl_pkg::FLAG_LE;
                    default: c.flag = ctrl_pkg::FLAG_GT;
                endcase
            end
            6'h08, 6'h09: begin
                c.opd_use = ctrl_pkg::OPD_RS;
                c.imm_sel = ctrl_pkg::IMM_SIGN;
                c.alu_op = ctrl_pkg::ALU_ADD;
                to_rt = 1'b1;
                if (!op[0])
                    c.exc_chk = ctrl_pkg::EXC_OVERFLOW;
            end
            6'h0a, 6'h0b: begin
                c.opd_use = ctrl_pkg::OPD_RS;
                c.imm_sel = ctrl_pkg::IMM_SIGN;
                c.reg_src = ctrl_pkg::REG_SRC_FLAG;
                c.flag = op[0] ? ctrl_pkg::FLAG_LTU : ctrl_pkg::FLAG_LT;
                to_rt = 1'b1;
            end
            6'h0c, 6'h0d, 6'h0e: begin
                c.opd_use = ctrl_pkg::OPD_RS;
                c.imm_sel = ctrl_pkg::IMM_ZERO;
                to_rt = 1'b1;
                case (op[1:0])
                    2'b00: c.alu_op = ctrl_pkg::ALU_AND;
                    2'b01: c.alu_op = ctrl_pkg::ALU_OR;
                    default: c.alu_op = ctrl_pkg::ALU_XOR;
                endcase
            end
            6'h0f: begin
                c.imm_sel = ctrl_pkg::IMM_UPPER;
                c.alu_op = ctrl_pkg::ALU_ADD;
                to_rt = 1'b1;
            end
            6'h20, 6'h21, 6'h23, 6'h24, 6'h25: begin
                c.opd_use = ctrl_pkg::OPD_RS;
                c.imm_sel = ctrl_pkg::IMM_SIGN;
                c.alu_op = ctrl_pkg::ALU_ADD;
                c.reg_src = ctrl_pkg::REG_SRC_MEM;
                to_rt = 1'b1;
                case (op[2:0])
                    3'b000: c.read_mode = ctrl_pkg::MEM_READ_BYTE;
                    3'b001: c.read_mode = ctrl_pkg::MEM_READ_HALF;
                    3'b100: c.read_mode = ctrl_pkg::MEM_READ_UBYTE;
                    3'b101: c.read_mode = ctrl_pkg::MEM_READ_UHALF;
                    default: c.read_mode = ctrl_pkg::MEM_READ_WORD;
                endcase
            end
            6'h28, 6'h29, 6'h2b: begin
                c.opd_use = ctrl_pkg::OPD_RS_RT;
                c.imm_sel = ctrl_pkg::IMM_SIGN;
                c.alu_op = ctrl_pkg::ALU_ADD;
                c.write_mem = 1'b1;
                case (op[1:0])
                    2'b00: c.write_mode = ctrl_pkg::MEM_WRITE_BYTE;
                    2'b01: c.write_mode = ctrl_pkg::MEM_WRITE_HALF;
                    default: c.write_mode = ctrl_pkg::MEM_WRITE_WORD;
                endcase
            end
            default: c = trap_control(ctrl_pkg::EXC_RESERVED);
        endcase
        if (to_rt) begin
            c.write_reg = 1'b1;
            c.dest_reg = ctrl_pkg::DEST_RT;
        end
        return c;
    endfunction

    task automatic step();
        @(posedge clk);
        #1; // inputs change and outputs are sampled away from the edge.
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp)
        else begin
            $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, got);
            test_errors++;
        end
    endtask

    task automatic check_outputs(input isa_pkg::instr_t w);
        check_value("ctl", 32'(ctl), 32'(expected_control(w)));
        check_value("rs", rs, w[25:21]);
        check_value("rt", rt, w[20:16]);
        check_value("rd", rd, w[15:11]);
        check_value("shamt", shamt, w[10:6]);
        check_value("imm", imm, w[15:0]);
    endtask

    // offers one word and checks it when out_valid rises.
    task automatic send_and_check(input isa_pkg::instr_t w, input bit is_reserved);
        int waited;
        in_valid = 1'b1;
        instruction = w;
        step();
        in_valid = 1'b0;
        step();
        waited = 1;
        while (!out_valid && waited < 20) begin
            step();
            waited++;
        end
        if (!out_valid) begin
            $display("timeout: out_valid did not rise within 20 cycles for word %h", w);
            test_errors++;
        end else begin
            checks++;
            assert (waited == 1)
            else begin
                $display("word %h appeared after %0d cycles instead of 1", w, waited);
                test_errors++;
            end
            check_outputs(w);
            if (is_reserved) begin
                check_value("ctl.pc_src", ctl.pc_src, ctrl_pkg::PC_EXCEPTION);
                check_value("ctl.exc_chk", ctl.exc_chk, ctrl_pkg::EXC_RESERVED);
                check_value("ctl.write_reg", ctl.write_reg, 1'b0);
                check_value("ctl.write_mem", ctl.write_mem, 1'b0);
            end
        end
    endtask

    task automatic finish_test(input string name);
        if (test_errors == 0)
            $display("test %s: passed", name);
        else
            $display("test %s: %0d errors", name, test_errors);
        errors += test_errors;
        test_errors = 0;
    endtask

    task automatic test_reset_state();
        check_value("out_valid", out_valid, 1'b0);
        check_value("ctl.write_reg", ctl.write_reg, 1'b0);
        check_value("ctl.write_mem", ctl.write_mem, 1'b0);
        check_value("ctl", 32'(ctl), 32'(idle_control()));
        finish_test("reset_state");
    endtask

    task automatic test_main_opcodes();
        logic [5:0] ops[$] = '{6'h02, 6'h03, 6'h04, 6'h05, 6'h06, 6'h07, 6'h08, 6'h09,
                               6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h0f, 6'h14, 6'h15,
                               6'h16, 6'h17, 6'h20, 6'h21, 6'h23, 6'h24, 6'h25, 6'h28,
                               6'h29, 6'h2b};
        foreach (ops[i]) begin
            rng = xorshift(rng);
            send_and_check({ops[i], rng[25:0]}, 1'b0);
        end
        finish_test("main_opcodes");
    endtask

    task automatic test_sub_decoders();
        logic [5:0] functs[$] = '{6'h20, 6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27,
                                  6'h2a, 6'h2b, 6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07,
                                  6'h08, 6'h09, 6'h0c, 6'h0d};
        logic [4:0] codes[$] = '{5'h00, 5'h01, 5'h10, 5'h11};
        logic [5:0] s2_functs[$] = '{6'h02, 6'h20, 6'h21};
        foreach (functs[i]) begin
            rng = xorshift(rng);
            send_and_check({6'h00, rng[25:6], functs[i]}, 1'b0);
        end
        foreach (codes[i]) begin
            rng = xorshift(rng);
            send_and_check({6'h01, rng[25:21], codes[i], rng[15:0]}, 1'b0);
        end
        foreach (s2_functs[i]) begin
            rng = xorshift(rng);
            send_and_check({6'h1c, rng[25:6], s2_functs[i]}, 1'b0);
        end
        finish_test("sub_decoders");
    endtask

    task automatic test_reserved();
        logic [5:0] ops[$] = '{6'h10, 6'h12, 6'h18, 6'h22, 6'h2a, 6'h3f};
        logic [5:0] functs[$] = '{6'h01, 6'h05, 6'h18, 6'h3f};
        foreach (ops[i]) begin
            rng = xorshift(rng);
            send_and_check({ops[i], rng[25:0]}, 1'b1);
        end
        foreach (functs[i]) begin
            rng = xorshift(rng);
            send_and_check({6'h00, rng[25:6], functs[i]}, 1'b1);
        end
        rng = xorshift(rng);
        send_and_check({6'h01, rng[25:21], 5'h02, rng[15:0]}, 1'b1);
        send_and_check({6'h01, rng[25:21], 5'h1f, rng[15:0]}, 1'b1);
        send_and_check({6'h1c, rng[25:6], 6'h00}, 1'b1);
        send_and_check({6'h1c, rng[25:6], 6'h3f}, 1'b1);
        finish_test("reserved");
    endtask

    task automatic test_handshake();
        isa_pkg::instr_t first;
        isa_pkg::instr_t second;
        rng = xorshift(rng);
        first = {6'h23, rng[25:0]}; // LW
        rng = xorshift(rng);
        second = {6'h00, rng[25:6], 6'h20}; // ADD
        send_and_check(first, 1'b0);
        stall = 1'b1;
        in_valid = 1'b1;
        instruction = second;
        repeat (3) begin
            step();
            check_value("out_valid", out_valid, 1'b1);
            check_outputs(first);
        end
        stall = 1'b0;
        in_valid = 1'b0;
        send_and_check(second, 1'b0);
        // back to back words, then a flush drops the second one in flight.
        in_valid = 1'b1;
        instruction = first;
        step();
        instruction = second;
        step();
        check_value("out_valid", out_valid, 1'b1);
        check_outputs(first);
        in_valid = 1'b0;
        flush = 1'b1;
        step();
        check_value("out_valid", out_valid, 1'b0);
        check_value("ctl.write_reg", ctl.write_reg, 1'b0);
        flush = 1'b0;
        instruction = first;
        repeat (3) begin
            step();
            check_value("out_valid", out_valid, 1'b0);
            check_value("ctl.write_mem", ctl.write_mem, 1'b0);
        end
        finish_test("handshake");
    endtask

    initial begin
        rng = 32'hd9d3dd08;
        checks = 0;
        errors = 0;
        test_errors = 0;
        reset = 1'b1;
        in_valid = 1'b0;
        instruction = '0;
        stall = 1'b0;
        flush = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        test_reset_state();
        test_main_opcodes();
        test_sub_decoders();
        test_reserved();
        test_handshake();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
